// ==== rtl/bubl_macros.svh ====
// Main bus constants
`ifndef BUBL_MACROS_SVH
`define BUBL_MACROS_SVH

////////////////////////////////////////////////////////////
// Address widths

// Work RAM, 8 KB
`define BUBL_WORK_AW 13

// Banked main ROM, 256 KB
`define BUBL_ROM_AW 18

// Address bus toward VRAM and palette
`define BUBL_VIDEO_AW 13

////////////////////////////////////////////////////////////
// Banking and read values

// Bank 0 sits right after the two fixed 16 KB pages
`define BUBL_BANK_BASE 2

// Unmapped reads float high
`define BUBL_OPEN_BUS 8'hff

`endif

// ==== rtl/bubl_pkg.sv ====
// Main bus types
`default_nettype none

`include "bubl_macros.svh"

package bubl_pkg;

    typedef logic [7:0] byte_t;                     // CPU data byte
    typedef logic [15:0] cpu_addr_t;                // Z80 address space

    // Memory addresses
    typedef logic [`BUBL_ROM_AW-1:0] rom_addr_t;
    typedef logic [`BUBL_WORK_AW-1:0] work_addr_t;

    typedef logic [2:0] bank_t;                     // 16 KB ROM page

    // Up, down, left, right and two buttons
    typedef logic [5:0] joy_t;

endpackage

`default_nettype wire

// ==== rtl/bubl_addr_decode.sv ====
// Main CPU memory map decoder
`timescale 1ns/10ps
`default_nettype none

module bubl_addr_decode (
    input  wire                tokio,
    input  bubl_pkg::cpu_addr_t addr,
    input  wire                mreq_n,
    input  wire                wr_n,
    output logic               rom_cs,
    output logic               vram_cs,
    output logic               pal_cs,
    output logic               work_cs,
    output logic               sound_cs,
    output logic               cab_cs,
    output logic               misc_cs,
    output logic               flip_cs,
    output logic               nmi_cs
);

    logic       mem;   // Memory cycle in progress
    logic       wr;
    logic [7:0] page;  // Upper address byte

    assign mem  = ~mreq_n;
    assign wr   = ~wr_n;
    assign page = addr[15:8];

    ////////////////////////////////////////////////////////////
    // Regions shared by both games

    always_comb begin
        rom_cs  = mem && addr[15:14] != 2'b11;                      // 0000-BFFF
        vram_cs = mem && addr[15:13] == 3'b110;                     // C000-DFFF
        work_cs = mem && addr[15:13] == 3'b111 && addr[12:11] != 2'b11;
        pal_cs  = mem && addr[15:9] == 7'b1111_100;                 // F800-F9FF
    end

    ////////////////////////////////////////////////////////////
    // I/O page, game dependent

    always_comb begin
        sound_cs = 1'b0;
        cab_cs   = 1'b0;
        misc_cs  = 1'b0;
        flip_cs  = 1'b0;
        nmi_cs   = 1'b0;
        if (tokio) begin
            sound_cs = mem && page == 8'hfc && !addr[7];
            cab_cs   = mem && page == 8'hfa && !addr[7] && !wr;
            misc_cs  = mem && page == 8'hfa && addr[7] && wr;
            flip_cs  = mem && page == 8'hfb && !addr[7] && wr;
            nmi_cs   = mem && page == 8'hfb && addr[7] && wr;
        end else begin
            // Inputs go through the MCU here, so no cabinet port
            sound_cs = mem && page == 8'hfa && !addr[7];
            misc_cs  = mem && page == 8'hfb && addr[7:6] == 2'b01 && wr;
            nmi_cs   = mem && page == 8'hfb && addr[7:6] == 2'b00 && wr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bubl_work_ram.sv ====
// Main work RAM
`timescale 1ns/10ps
`default_nettype none

`include "bubl_macros.svh"

module bubl_work_ram (
    input  wire                  clk24,
    input  wire                  we,
    input  bubl_pkg::work_addr_t addr,
    input  bubl_pkg::byte_t      din,
    output bubl_pkg::byte_t      q
);

    localparam int DEPTH = 2 ** `BUBL_WORK_AW;

    bubl_pkg::byte_t mem [0:DEPTH-1];

    // Old data comes out during a write
    always_ff @(posedge clk24) begin
        if (we) begin
            mem[addr] <= din;
        end
        q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/bubl_ctrl_latch.sv ====
// Board control latch
`timescale 1ns/10ps
`default_nettype none

module bubl_ctrl_latch (
    input  wire             clk24,
    input  wire             rst,
    input  wire             tokio,
    input  wire             misc_cs,
    input  wire             flip_cs,
    input  bubl_pkg::byte_t data,
    output bubl_pkg::bank_t bank,
    output logic            black_n,
    output logic            flip,
    output logic            sub_rstn
);

    logic flip_we;

    // Tokio moved flip to its own address
    assign flip_we = tokio ? flip_cs : misc_cs;

    ////////////////////////////////////////////////////////////
    // Misc register

    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            bank     <= '0;
            black_n  <= 1'b0;   // Screen blanked until the game is up
            sub_rstn <= 1'b0;
        end else if (misc_cs) begin
            if (tokio) begin
                bank     <= data[2:0];
                sub_rstn <= 1'b1;
            end else begin
                bank     <= data[2:0] ^ 3'b100;  // Top bank bit inverted on this PCB
                sub_rstn <= data[4];
            end
            black_n <= data[6];
        end
    end

    ////////////////////////////////////////////////////////////
    // Screen flip

    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            flip <= 1'b0;
        end else if (flip_we) begin
            flip <= data[7];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bubl_sound_comm.sv ====
// Sound CPU mailbox
`timescale 1ns/10ps
`default_nettype none

module bubl_sound_comm (
    input  wire             clk24,
    input  wire             rst,
    input  wire             sound_cs,
    input  wire             wr_n,
    input  wire             rd_n,
    input  wire [1:0]       offset,
    input  bubl_pkg::byte_t data,
    input  wire             main_stb,
    output bubl_pkg::byte_t snd_latch,
    output logic            snd_stb,
    output logic            snd_rstn,
    output logic            main_flag
);

    logic cmd_wr;    // Command byte write
    logic rst_wr;    // Sound reset write
    logic flag_rd;
    logic last_stb;

    assign cmd_wr  = sound_cs && !wr_n && offset == 2'd0;
    assign rst_wr  = sound_cs && !wr_n && offset == 2'd3;
    assign flag_rd = sound_cs && !rd_n;

    ////////////////////////////////////////////////////////////
    // Main to sound direction

    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_stb   <= 1'b0;
            snd_rstn  <= 1'b1;      // Sound CPU runs from power up
        end else begin
            snd_stb <= cmd_wr;      // One pulse per write cycle
            if (cmd_wr) begin
                snd_latch <= data;
            end
            if (rst_wr) begin
                snd_rstn <= ~data[0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Sound to main flag

    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            last_stb  <= 1'b0;
            main_flag <= 1'b0;
        end else begin
            last_stb <= main_stb;
            if (flag_rd) begin
                main_flag <= 1'b0;  // Read wins over a new edge
            end else if (main_stb && !last_stb) begin
                main_flag <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bubl_cabinet_port.sv ====
// Tokio cabinet inputs
`timescale 1ns/10ps
`default_nettype none

`include "bubl_macros.svh"

module bubl_cabinet_port (
    input  wire             clk24,
    input  wire [2:0]       sel,
    input  bubl_pkg::byte_t dipsw_a,
    input  bubl_pkg::byte_t dipsw_b,
    input  wire [1:0]       coin_input,
    input  wire [1:0]       start_button,
    input  bubl_pkg::joy_t  joystick1,
    input  bubl_pkg::joy_t  joystick2,
    output bubl_pkg::byte_t cab_dout
);

    // Player byte as wired on the board
    function automatic bubl_pkg::byte_t player_byte(input logic start, input bubl_pkg::joy_t joy);
        player_byte = {1'b1, start, joy[4], joy[5], joy[3:2], joy[0], joy[1]};
    endfunction

    always_ff @(posedge clk24) begin
        case (sel)
            3'd3: cab_dout <= dipsw_a;
            3'd4: cab_dout <= dipsw_b;
            3'd5: cab_dout <= {2'b11, 2'b11, coin_input, 2'b11};   // Bits 5:4 unused here
            3'd6: cab_dout <= player_byte(start_button[0], joystick1);
            3'd7: cab_dout <= player_byte(start_button[1], joystick2);
            default: cab_dout <= `BUBL_OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/bubl_main_bus.sv ====
// Main CPU bus glue
`timescale 1ns/10ps
`default_nettype none

`include "bubl_macros.svh"

module bubl_main_bus (
    input  wire                       clk24,
    input  wire                       rst,
    input  wire                       tokio,
    // Main CPU
    input  bubl_pkg::cpu_addr_t       addr,
    input  wire                       mreq_n,
    input  wire                       wr_n,
    input  wire                       rd_n,
    input  bubl_pkg::byte_t           dout,
    output bubl_pkg::byte_t           din,
    // Video
    input  bubl_pkg::byte_t           vram_dout,
    input  bubl_pkg::byte_t           pal_dout,
    output logic                      vram_cs,
    output logic                      pal_cs,
    output logic [`BUBL_VIDEO_AW-1:0] cpu_addr,
    output bubl_pkg::byte_t           cpu_dout,
    output logic                      cpu_rnw,
    output logic                      black_n,
    output logic                      flip,
    // ROM
    input  bubl_pkg::byte_t           main_rom_data,
    output bubl_pkg::rom_addr_t       main_rom_addr,
    output logic                      main_rom_cs,
    // Sub CPU
    output logic                      sub_rstn,
    output logic                      sub_nmi,
    // Sound
    input  bubl_pkg::byte_t           main_latch,
    input  wire                       snd_flag,
    input  wire                       main_stb,
    output bubl_pkg::byte_t           snd_latch,
    output logic                      snd_stb,
    output logic                      snd_rstn,
    output logic                      main_flag,
    // Cabinet
    input  wire [1:0]                 coin_input,
    input  wire [1:0]                 start_button,
    input  bubl_pkg::joy_t            joystick1,
    input  bubl_pkg::joy_t            joystick2,
    input  bubl_pkg::byte_t           dipsw_a,
    input  bubl_pkg::byte_t           dipsw_b
);

    logic            rom_cs, work_cs, sound_cs, cab_cs;
    logic            misc_cs, flip_cs, nmi_cs;
    bubl_pkg::bank_t bank;
    bubl_pkg::byte_t work_q, cab_dout, snd_status;
    logic [3:0]      bank_hi;   // ROM address bits 17:14

    assign cpu_addr    = addr[`BUBL_VIDEO_AW-1:0];
    assign cpu_dout    = dout;
    assign cpu_rnw     = wr_n;
    assign main_rom_cs = rom_cs;
    assign sub_nmi     = nmi_cs;
    assign snd_status  = {6'h3f, main_flag, snd_flag};

    ////////////////////////////////////////////////////////////
    // ROM banking

    assign bank_hi       = {1'b0, bank} + 4'(`BUBL_BANK_BASE);
    assign main_rom_addr = addr[15] ? {bank_hi, addr[13:0]}            // 8000-BFFF window
                                    : bubl_pkg::rom_addr_t'(addr[14:0]);

    ////////////////////////////////////////////////////////////
    // Read mux, priority order

    always_ff @(posedge clk24) begin
        if (rom_cs)        din <= main_rom_data;
        else if (vram_cs)  din <= vram_dout;
        else if (pal_cs)   din <= pal_dout;
        else if (work_cs)  din <= work_q;
        else if (sound_cs) din <= addr[0] ? snd_status : main_latch;
        else if (cab_cs)   din <= cab_dout;
        else               din <= `BUBL_OPEN_BUS;  // Shared RAM window lands here too
    end

    ////////////////////////////////////////////////////////////
    // Blocks

    bubl_addr_decode u_decode (
        .tokio    (tokio),
        .addr     (addr),
        .mreq_n   (mreq_n),
        .wr_n     (wr_n),
        .rom_cs   (rom_cs),
        .vram_cs  (vram_cs),
        .pal_cs   (pal_cs),
        .work_cs  (work_cs),
        .sound_cs (sound_cs),
        .cab_cs   (cab_cs),
        .misc_cs  (misc_cs),
        .flip_cs  (flip_cs),
        .nmi_cs   (nmi_cs)
    );

    bubl_work_ram u_work (
        .clk24 (clk24),
        .we    (work_cs && !wr_n),
        .addr  (addr[`BUBL_WORK_AW-1:0]),
        .din   (dout),
        .q     (work_q)
    );

    bubl_ctrl_latch u_ctrl (
        .clk24    (clk24),
        .rst      (rst),
        .tokio    (tokio),
        .misc_cs  (misc_cs),
        .flip_cs  (flip_cs),
        .data     (dout),
        .bank     (bank),
        .black_n  (black_n),
        .flip     (flip),
        .sub_rstn (sub_rstn)
    );

    bubl_sound_comm u_sound (
        .clk24     (clk24),
        .rst       (rst),
        .sound_cs  (sound_cs),
        .wr_n      (wr_n),
        .rd_n      (rd_n),
        .offset    (addr[1:0]),
        .data      (dout),
        .main_stb  (main_stb),
        .snd_latch (snd_latch),
        .snd_stb   (snd_stb),
        .snd_rstn  (snd_rstn),
        .main_flag (main_flag)
    );

    bubl_cabinet_port u_cab (
        .clk24        (clk24),
        .sel          (addr[2:0]),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .coin_input   (coin_input),
        .start_button (start_button),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .cab_dout     (cab_dout)
    );

endmodule

`default_nettype wire

// ==== tb/bubl_main_bus_tb.sv ====
// Main bus testbench
`timescale 1ns/10ps
`default_nettype none

`include "bubl_macros.svh"

module bubl_main_bus_tb;

    logic                      clk24;
    logic                      rst;
    logic                      tokio;
    bubl_pkg::cpu_addr_t       addr;
    logic                      mreq_n, wr_n, rd_n;
    bubl_pkg::byte_t           dout, din;
    bubl_pkg::byte_t           vram_dout, pal_dout, main_rom_data;
    logic                      vram_cs, pal_cs, cpu_rnw;
    logic [`BUBL_VIDEO_AW-1:0] cpu_addr;
    bubl_pkg::byte_t           cpu_dout;
    logic                      black_n, flip, sub_rstn, sub_nmi;
    bubl_pkg::rom_addr_t       main_rom_addr;
    logic                      main_rom_cs;
    bubl_pkg::byte_t           main_latch, snd_latch;
    logic                      snd_flag, main_stb, snd_stb, snd_rstn, main_flag;
    logic [1:0]                coin_input, start_button;
    bubl_pkg::joy_t            joystick1, joystick2;
    bubl_pkg::byte_t           dipsw_a, dipsw_b;

    // Reference model state
    integer              seed;
    integer              errors;
    bubl_pkg::byte_t     ram_model [0:2**`BUBL_WORK_AW-1];
    bit                  ram_valid [0:2**`BUBL_WORK_AW-1];
    bubl_pkg::cpu_addr_t ram_list [$];
    bubl_pkg::bank_t     bank_model;
    logic                black_model, flip_model, sub_model;
    bubl_pkg::byte_t     latch_model;
    logic                rstn_model, flag_model;
    logic                sel_rom, sel_vram, sel_pal, sel_nmi;   // Selects seen mid-access

    bubl_main_bus UUT (.*);

    initial begin
        clk24 = 1'b0;
        forever #5 clk24 = ~clk24;
    end

    ////////////////////////////////////////////////////////////
    // Checks

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_byte(input string name, input bubl_pkg::byte_t got,
                              input bubl_pkg::byte_t want);
        if (got !== want)
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic check_rom_addr(input string name, input bubl_pkg::rom_addr_t got,
                                  input bubl_pkg::rom_addr_t want);
        if (got !== want)
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic check_video_addr(input string name, input logic [`BUBL_VIDEO_AW-1:0] got,
                                    input logic [`BUBL_VIDEO_AW-1:0] want);
        if (got !== want)
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, want));
    endtask

    // Bank is read back from the upper ROM address, so addr must be 8000 or above
    task automatic check_bank_ctrl(input bubl_pkg::bank_t want_bank, input logic [2:0] want_ctrl);
        bubl_pkg::bank_t got_bank;
        got_bank = bubl_pkg::bank_t'(main_rom_addr[`BUBL_ROM_AW-1 -: 4] - 4'(`BUBL_BANK_BASE));
        check_byte("bank", 8'(got_bank), 8'(want_bank));
        check_bit("black_n", black_n, want_ctrl[2]);
        check_bit("flip", flip, want_ctrl[1]);
        check_bit("sub_rstn", sub_rstn, want_ctrl[0]);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory map model

    function automatic logic in_range(input bubl_pkg::cpu_addr_t a, input int lo, input int hi);
        return int'(a) >= lo && int'(a) <= hi;
    endfunction

    function automatic logic sound_sel(input bubl_pkg::cpu_addr_t a);
        return tokio ? in_range(a, 'hfc00, 'hfc7f) : in_range(a, 'hfa00, 'hfa7f);
    endfunction

    function automatic logic misc_sel(input bubl_pkg::cpu_addr_t a);
        return tokio ? in_range(a, 'hfa80, 'hfaff) : in_range(a, 'hfb40, 'hfb7f);
    endfunction

    function automatic logic nmi_sel(input bubl_pkg::cpu_addr_t a);
        return tokio ? in_range(a, 'hfb80, 'hfbff) : in_range(a, 'hfb00, 'hfb3f);
    endfunction

    function automatic bubl_pkg::cpu_addr_t rand_addr(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return 16'(lo + int'(r % (hi - lo + 1)));
    endfunction

    // Player byte is one, start, then joystick bits 4 5 3 2 0 1
    function automatic bubl_pkg::byte_t cab_model(input logic [2:0] sel);
        bubl_pkg::joy_t j;
        logic           s;
        j = sel[0] ? joystick2 : joystick1;
        s = sel[0] ? start_button[1] : start_button[0];
        case (sel)
            3'd3: return dipsw_a;
            3'd4: return dipsw_b;
            3'd5: return {4'hf, coin_input, 2'b11};
            3'd6, 3'd7: return {1'b1, s, j[4], j[5], j[3], j[2], j[0], j[1]};
            default: return `BUBL_OPEN_BUS;
        endcase
    endfunction

    task automatic model_read(input bubl_pkg::cpu_addr_t a, input int cycles,
                              output bubl_pkg::byte_t want, output logic known);
        known = 1'b1;
        if (in_range(a, 0, 'hbfff)) want = main_rom_data;
        else if (in_range(a, 'hc000, 'hdfff)) want = vram_dout;
        else if (in_range(a, 'hf800, 'hf9ff)) want = pal_dout;
        else if (in_range(a, 'he000, 'hf7ff)) begin
            want  = ram_model[a[`BUBL_WORK_AW-1:0]];
            known = ram_valid[a[`BUBL_WORK_AW-1:0]];
        end else if (sound_sel(a)) begin
            // Flag is already cleared when a longer read is sampled
            want = a[0] ? {6'h3f, (cycles == 1) ? flag_model : 1'b0, snd_flag} : main_latch;
            flag_model = 1'b0;
        end else if (tokio && in_range(a, 'hfa00, 'hfa7f)) want = cab_model(a[2:0]);
        else want = `BUBL_OPEN_BUS;
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles

    task automatic bus_cycle(input bubl_pkg::cpu_addr_t a, input logic wr,
                             input bubl_pkg::byte_t d, input int cycles);
        @(posedge clk24);
        addr   <= a;
        dout   <= d;
        mreq_n <= 1'b0;
        wr_n   <= ~wr;
        rd_n   <= wr;
        @(negedge clk24);
        sel_rom  = main_rom_cs;
        sel_vram = vram_cs;
        sel_pal  = pal_cs;
        sel_nmi  = sub_nmi;
        check_bit("cpu_rnw", cpu_rnw, ~wr);
        check_byte("cpu_dout", cpu_dout, d);
        check_video_addr("cpu_addr", cpu_addr, a[`BUBL_VIDEO_AW-1:0]);
        repeat (cycles - 1) @(posedge clk24);
        @(posedge clk24);         // Last edge that sees the access
        mreq_n <= 1'b1;
        wr_n   <= 1'b1;
        rd_n   <= 1'b1;
        @(negedge clk24);
    endtask

    task automatic read_check(input bubl_pkg::cpu_addr_t a, input int cycles);
        bubl_pkg::byte_t want;
        logic            known;
        model_read(a, cycles, want, known);
        bus_cycle(a, 1'b0, 8'h00, cycles);
        check_bit("main_rom_cs", sel_rom, in_range(a, 0, 'hbfff));
        check_bit("vram_cs", sel_vram, in_range(a, 'hc000, 'hdfff));
        check_bit("pal_cs", sel_pal, in_range(a, 'hf800, 'hf9ff));
        check_bit("sub_nmi", sel_nmi, 1'b0);
        if (known) check_byte("din", din, want);
    endtask

    task automatic write_bus(input bubl_pkg::cpu_addr_t a, input bubl_pkg::byte_t d,
                             input int cycles);
        bus_cycle(a, 1'b1, d, cycles);
        check_bit("sub_nmi", sel_nmi, nmi_sel(a));
        if (in_range(a, 'he000, 'hf7ff)) begin
            ram_model[a[`BUBL_WORK_AW-1:0]] = d;
            ram_valid[a[`BUBL_WORK_AW-1:0]] = 1'b1;
        end
        if (misc_sel(a)) begin
            bank_model  = tokio ? d[2:0] : {~d[2], d[1:0]};
            black_model = d[6];
            sub_model   = tokio ? 1'b1 : d[4];
            if (!tokio) flip_model = d[7];
        end
        if (tokio && in_range(a, 'hfb00, 'hfb7f)) flip_model = d[7];
        if (sound_sel(a) && a[1:0] == 2'd0) latch_model = d;
        if (sound_sel(a) && a[1:0] == 2'd3) rstn_model = ~d[0];
    endtask

    task automatic randomize_inputs;
        @(posedge clk24);
        vram_dout     <= 8'($random(seed));
        pal_dout      <= 8'($random(seed));
        main_rom_data <= 8'($random(seed));
        main_latch    <= 8'($random(seed));
        snd_flag      <= 1'($random(seed));
        dipsw_a       <= 8'($random(seed));
        dipsw_b       <= 8'($random(seed));
        coin_input    <= 2'($random(seed));
        start_button  <= 2'($random(seed));
        joystick1     <= 6'($random(seed));
        joystick2     <= 6'($random(seed));
        @(negedge clk24);
    endtask

    // ROM address in the banked window and below it
    task automatic control_check;
        bubl_pkg::cpu_addr_t a;
        bubl_pkg::rom_addr_t want;
        a = rand_addr('h8000, 'hbfff);
        @(posedge clk24);
        addr <= a;
        @(negedge clk24);
        want = {4'(bank_model) + 4'(`BUBL_BANK_BASE), a[13:0]};
        check_rom_addr("main_rom_addr", main_rom_addr, want);
        check_bank_ctrl(bank_model, {black_model, flip_model, sub_model});
        a = rand_addr(0, 'h7fff);
        @(posedge clk24);
        addr <= a;
        @(negedge clk24);
        check_rom_addr("main_rom_addr", main_rom_addr, bubl_pkg::rom_addr_t'(a[14:0]));
    endtask

    task automatic sound_state_check;
        check_byte("snd_latch", snd_latch, latch_model);
        check_bit("snd_rstn", snd_rstn, rstn_model);
        check_bit("main_flag", main_flag, flag_model);
    endtask

    task automatic reset_dut(input logic game);
        @(posedge clk24);
        rst   <= 1'b1;
        tokio <= game;
        repeat (5) @(posedge clk24);
        rst <= 1'b0;
        @(negedge clk24);
        bank_model  = '0;
        black_model = 1'b0;
        flip_model  = 1'b0;
        sub_model   = 1'b0;
        latch_model = '0;
        rstn_model  = 1'b1;
        flag_model  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        bubl_pkg::cpu_addr_t a;
        bubl_pkg::byte_t     d;
        int                  wait_cycles;
        seed   = 32'h39e9e08e;
        errors = 0;
        rst    = 1'b1;
        tokio  = 1'b0;
        addr   = '0;
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        rd_n   = 1'b1;
        dout   = '0;
        {vram_dout, pal_dout, main_rom_data, main_latch} = '0;
        {snd_flag, main_stb, coin_input, start_button} = '0;
        {joystick1, joystick2, dipsw_a, dipsw_b} = '0;

        for (int game = 0; game < 2; game++) begin
            reset_dut(game[0]);
            control_check();                  // Values straight out of reset
            sound_state_check();
            check_bit("snd_stb", snd_stb, 1'b0);

            for (int i = 0; i < 300; i++) begin
                randomize_inputs();
                a = (i % 2 == 1) ? rand_addr('hf800, 'hffff) : rand_addr(0, 'hffff);
                read_check(a, 4);
            end

            for (int i = 0; i < 200; i++) begin
                a = rand_addr('he000, 'hf7ff);
                write_bus(a, 8'($random(seed)), 4);
                ram_list.push_back(a);
                read_check(ram_list[rand_addr(0, ram_list.size() - 1)], 4);
            end

            // Misc, flip and sub NMI all live in FA80-FBFF
            for (int i = 0; i < 120; i++) begin
                write_bus(rand_addr('hfa80, 'hfbff), 8'($random(seed)), 4);
                control_check();
            end

            for (int i = 0; i < 40; i++) begin
                randomize_inputs();
                a = tokio ? rand_addr('hfc00, 'hfc7f) : rand_addr('hfa00, 'hfa7f);
                d = 8'($random(seed));
                write_bus({a[15:2], 2'd0}, d, 1);
                check_bit("snd_stb", snd_stb, 1'b1);
                @(negedge clk24);
                check_bit("snd_stb", snd_stb, 1'b0);
                write_bus({a[15:2], 2'd3}, 8'($random(seed)), 4);
                sound_state_check();
                @(posedge clk24);
                main_stb <= 1'b1;
                wait_cycles = 0;
                while (main_flag !== 1'b1) begin
                    @(negedge clk24);
                    wait_cycles++;
                    if (wait_cycles > 8)
                        abort_run("main_flag never rose after a main_stb edge");
                end
                flag_model = 1'b1;
                @(posedge clk24);
                main_stb <= 1'b0;
                read_check({a[15:2], 2'd1}, 1);
                sound_state_check();
                read_check({a[15:2], 2'd2}, 4);
            end

            // Cabinet port in Tokio, sound or open bus otherwise
            for (int i = 0; i < 16; i++) begin
                randomize_inputs();
                for (int s = 0; s < 8; s++) begin
                    a = rand_addr('hfa00, 'hfa7f);
                    read_check({a[15:3], 3'(s)}, 4);
                end
            end
        end

        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("Errors were recorded during the run");
        end
    end

endmodule

`default_nettype wire

// ==== bubl_main_bus.f ====
+incdir+rtl
rtl/bubl_pkg.sv
rtl/bubl_addr_decode.sv
rtl/bubl_work_ram.sv
rtl/bubl_ctrl_latch.sv
rtl/bubl_sound_comm.sv
rtl/bubl_cabinet_port.sv
rtl/bubl_main_bus.sv
tb/bubl_main_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the main bus testbench with Verilator

cd "$(dirname "$0")" \
    && verilator --binary -j 0 --timescale 1ns/10ps --top-module bubl_main_bus_tb \
        -f bubl_main_bus.f -o bubl_main_bus_sim \
    && ./obj_dir/bubl_main_bus_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; test -s sim.log \
    && ! grep -q "=== FAIL ===" sim.log \
    || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
